//--- hw/sha256_core.sv
`timescale 1ns/1ps
`include "sha256_macros.svh"

module sha256_core (
  input  logic                clk,
  input  logic                reset_n,
  input  logic                zeroize,
  input  logic                init_cmd,
  input  logic                next_cmd,
  input  sha256_pkg::block_t  block,
  output logic                ready,
  output logic                digest_valid,
  output sha256_pkg::digest_t digest
);
  import sha256_pkg::*;

  // ---------------------------------------------------------------------
  // state
  // ---------------------------------------------------------------------
  // rounds in progress
  logic       busy_q;
  // final add of working vars into H
  logic       fin_q;
  logic       valid_q;
  round_idx_t round_q;
  digest_t    chain_q;
  // working variables
  word_t      a_q;
  word_t      b_q;
  word_t      c_q;
  word_t      d_q;
  word_t      e_q;
  word_t      f_q;
  word_t      g_q;
  word_t      h_q;

  logic       start;
  logic       last_round;
  digest_t    seed;
  word_t      w;
  word_t      t1;
  word_t      t2;

  // commands only count while idle
  assign start      = ready & (init_cmd | next_cmd);
  assign last_round = (round_q == round_idx_t'(`SHA256_ROUNDS - 1));
  // init restarts from iv, next chains from current H
  assign seed       = init_cmd ? sha256_iv : chain_q;

  sha256_msg_schedule u_sha256_msg_schedule (
    .clk     (clk),
    .reset_n (reset_n),
    .load    (start),
    .advance (busy_q),
    .clear   (zeroize),
    .block   (block),
    .w       (w)
  );

  // one compression round
  always_comb begin
    t1 = h_q + big_sigma1(e_q) + choose(e_q, f_q, g_q) + round_constant(round_q) + w;
    t2 = big_sigma0(a_q) + majority(a_q, b_q, c_q);
  end

  // ---------------------------------------------------------------------
  // round engine
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      busy_q  <= 1'b0;
      fin_q   <= 1'b0;
      valid_q <= 1'b0;
      round_q <= '0;
      chain_q <= '0;
      {a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q} <= '0;
    end else if (zeroize) begin
      // abort and wipe, back to ready
      busy_q  <= 1'b0;
      fin_q   <= 1'b0;
      valid_q <= 1'b0;
      round_q <= '0;
      chain_q <= '0;
      {a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q} <= '0;
    end else if (start) begin
      busy_q  <= 1'b1;
      valid_q <= 1'b0;
      round_q <= '0;
      chain_q <= seed;
      {a_q, b_q, c_q, d_q, e_q, f_q, g_q, h_q} <= seed;
    end else if (busy_q) begin
      a_q     <= t1 + t2;
      b_q     <= a_q;
      c_q     <= b_q;
      d_q     <= c_q;
      e_q     <= d_q + t1;
      f_q     <= e_q;
      g_q     <= f_q;
      h_q     <= g_q;
      round_q <= round_q + 1'b1;
      if (last_round) begin
        busy_q <= 1'b0;
        fin_q  <= 1'b1;
      end
    end else if (fin_q) begin
      // fold working vars into H
      chain_q <= {chain_q[0] + a_q, chain_q[1] + b_q, chain_q[2] + c_q, chain_q[3] + d_q,
                  chain_q[4] + e_q, chain_q[5] + f_q, chain_q[6] + g_q, chain_q[7] + h_q};
      fin_q   <= 1'b0;
      valid_q <= 1'b1;
    end
  end

  assign ready        = ~(busy_q | fin_q);
  assign digest_valid = valid_q;
  assign digest       = chain_q;

endmodule

//--- hw/sha256_macros.svh
`ifndef SHA256_MACROS_SVH
`define SHA256_MACROS_SVH

// ---------------------------------------------------------------------
// sizes
// ---------------------------------------------------------------------
`define SHA256_WORD_W        32
`define SHA256_BLOCK_WORDS   16
`define SHA256_DIGEST_WORDS  8
`define SHA256_ROUNDS        64
// wishbone word address, not byte address
`define SHA256_ADR_W         5

// ---------------------------------------------------------------------
// register map
// ---------------------------------------------------------------------
// block words 0..15 start here
`define SHA256_ADR_BLOCK     5'h00
`define SHA256_ADR_CTRL      5'h10
`define SHA256_ADR_STATUS    5'h11
`define SHA256_ADR_INTR_STS  5'h12
`define SHA256_ADR_INTR_EN   5'h13
// digest words 0..7, word 0 is H0
`define SHA256_ADR_DIGEST    5'h18

// ctrl bits, write-only pulses
`define SHA256_CTRL_INIT     0
`define SHA256_CTRL_NEXT     1
`define SHA256_CTRL_ZEROIZE  2

// status bits
`define SHA256_STS_READY     0
`define SHA256_STS_VALID     1

`endif

//--- hw/sha256_msg_schedule.sv
`timescale 1ns/1ps
`include "sha256_macros.svh"

module sha256_msg_schedule (
  input  logic               clk,
  input  logic               reset_n,
  input  logic               load,
  input  logic               advance,
  input  logic               clear,
  input  sha256_pkg::block_t block,
  output sha256_pkg::word_t  w
);
  import sha256_pkg::*;

  // window[0] is the oldest word, W[t-16] relative to the next word
  block_t window;
  word_t  w_new;

  // W[t] = s1(W[t-2]) + W[t-7] + s0(W[t-15]) + W[t-16]
  always_comb begin
    w_new = small_sigma1(window[`SHA256_BLOCK_WORDS - 2])
          + window[`SHA256_BLOCK_WORDS - 7]
          + small_sigma0(window[`SHA256_BLOCK_WORDS - 15])
          + window[`SHA256_BLOCK_WORDS - 16];
  end

  // ---------------------------------------------------------------------
  // window shift register
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      window <= '0;
    end else if (clear) begin
      // zeroize wipes message words too
      window <= '0;
    end else if (load) begin
      window <= block;
    end else if (advance) begin
      // drop oldest, append newest
      window <= {window[1:`SHA256_BLOCK_WORDS - 1], w_new};
    end
  end

  // current round word
  assign w = window[0];

endmodule

//--- hw/sha256_pkg.sv
package sha256_pkg;

  // ---------------------------------------------------------------------
  // types
  // ---------------------------------------------------------------------
  typedef logic [31:0] word_t;
  // word 0 sits in the msb position of the block
  typedef word_t [0:15] block_t;
  // word 0 is H0
  typedef word_t [0:7] digest_t;
  typedef logic [5:0] round_idx_t;

  // round constants K0..K63
  localparam word_t sha256_k [0:63] = '{
    32'h428a2f98, 32'h71374491, 32'hb5c0fbcf, 32'he9b5dba5,
    32'h3956c25b, 32'h59f111f1, 32'h923f82a4, 32'hab1c5ed5,
    32'hd807aa98, 32'h12835b01, 32'h243185be, 32'h550c7dc3,
    32'h72be5d74, 32'h80deb1fe, 32'h9bdc06a7, 32'hc19bf174,
    32'he49b69c1, 32'hefbe4786, 32'h0fc19dc6, 32'h240ca1cc,
    32'h2de92c6f, 32'h4a7484aa, 32'h5cb0a9dc, 32'h76f988da,
    32'h983e5152, 32'ha831c66d, 32'hb00327c8, 32'hbf597fc7,
    32'hc6e00bf3, 32'hd5a79147, 32'h06ca6351, 32'h14292967,
    32'h27b70a85, 32'h2e1b2138, 32'h4d2c6dfc, 32'h53380d13,
    32'h650a7354, 32'h766a0abb, 32'h81c2c92e, 32'h92722c85,
    32'ha2bfe8a1, 32'ha81a664b, 32'hc24b8b70, 32'hc76c51a3,
    32'hd192e819, 32'hd6990624, 32'hf40e3585, 32'h106aa070,
    32'h19a4c116, 32'h1e376c08, 32'h2748774c, 32'h34b0bcb5,
    32'h391c0cb3, 32'h4ed8aa4a, 32'h5b9cca4f, 32'h682e6ff3,
    32'h748f82ee, 32'h78a5636f, 32'h84c87814, 32'h8cc70208,
    32'h90befffa, 32'ha4506ceb, 32'hbef9a3f7, 32'hc67178f2
  };

  // standard initial hash value H0..H7
  localparam digest_t sha256_iv = {
    32'h6a09e667, 32'hbb67ae85, 32'h3c6ef372, 32'ha54ff53a,
    32'h510e527f, 32'h9b05688c, 32'h1f83d9ab, 32'h5be0cd19
  };

  function automatic word_t round_constant(input round_idx_t idx);
    return sha256_k[idx];
  endfunction

  // ---------------------------------------------------------------------
  // bit functions, rotations written as slices
  // ---------------------------------------------------------------------
  function automatic word_t big_sigma0(input word_t x);
    return {x[1:0], x[31:2]} ^ {x[12:0], x[31:13]} ^ {x[21:0], x[31:22]};
  endfunction

  function automatic word_t big_sigma1(input word_t x);
    return {x[5:0], x[31:6]} ^ {x[10:0], x[31:11]} ^ {x[24:0], x[31:25]};
  endfunction

  function automatic word_t small_sigma0(input word_t x);
    return {x[6:0], x[31:7]} ^ {x[17:0], x[31:18]} ^ {3'b000, x[31:3]};
  endfunction

  function automatic word_t small_sigma1(input word_t x);
    return {x[16:0], x[31:17]} ^ {x[18:0], x[31:19]} ^ {10'b0, x[31:10]};
  endfunction

  function automatic word_t choose(input word_t x, input word_t y, input word_t z);
    return (x & y) ^ (~x & z);
  endfunction

  function automatic word_t majority(input word_t x, input word_t y, input word_t z);
    return (x & y) ^ (x & z) ^ (y & z);
  endfunction

endpackage

//--- hw/sha256_regs.sv
`timescale 1ns/1ps
`include "sha256_macros.svh"

module sha256_regs (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`SHA256_ADR_W-1:0] wb_adr,
  input  sha256_pkg::word_t        wb_dat_w,
  output sha256_pkg::word_t        wb_dat_r,
  output logic                     wb_ack,
  output logic                     wb_err,
  output logic                     notif_intr,
  output logic                     init_cmd,
  output logic                     next_cmd,
  output logic                     zeroize,
  output sha256_pkg::block_t       block,
  input  logic                     ready,
  input  logic                     digest_valid,
  input  sha256_pkg::digest_t      digest
);
  import sha256_pkg::*;

  localparam int BLK_IDX_W = $clog2(`SHA256_BLOCK_WORDS);
  localparam int DIG_IDX_W = $clog2(`SHA256_DIGEST_WORDS);

  logic                     req;
  logic                     wr_req;
  logic                     rd_req;
  logic [`SHA256_ADR_W-1:0] blk_off;
  logic [`SHA256_ADR_W-1:0] dig_off;
  logic                     sel_block;
  logic                     sel_ctrl;
  logic                     sel_status;
  logic                     sel_intr_sts;
  logic                     sel_intr_en;
  logic                     sel_digest;
  logic                     mapped;
  logic                     intr_sts_q;
  logic                     intr_en_q;
  // delayed digest_valid for edge detect
  logic                     valid_q;
  word_t                    rd_mux;

  // ---------------------------------------------------------------------
  // wishbone decode
  // ---------------------------------------------------------------------
  // held request is not taken again while the answer is out
  assign req    = wb_cyc & wb_stb & ~wb_ack & ~wb_err;
  assign wr_req = req & wb_we & mapped;
  assign rd_req = req & ~wb_we & mapped;

  // offsets wrap, so one compare covers each window
  assign blk_off      = wb_adr - `SHA256_ADR_BLOCK;
  assign dig_off      = wb_adr - `SHA256_ADR_DIGEST;
  assign sel_block    = (blk_off < `SHA256_BLOCK_WORDS);
  assign sel_digest   = (dig_off < `SHA256_DIGEST_WORDS);
  assign sel_ctrl     = (wb_adr == `SHA256_ADR_CTRL);
  assign sel_status   = (wb_adr == `SHA256_ADR_STATUS);
  assign sel_intr_sts = (wb_adr == `SHA256_ADR_INTR_STS);
  assign sel_intr_en  = (wb_adr == `SHA256_ADR_INTR_EN);
  assign mapped       = sel_block | sel_digest | sel_ctrl | sel_status |
                        sel_intr_sts | sel_intr_en;

  // read mux, ctrl reads back zero
  always_comb begin
    rd_mux = '0;
    if (sel_block) begin
      rd_mux = block[blk_off[BLK_IDX_W-1:0]];
    end else if (sel_status) begin
      rd_mux[`SHA256_STS_READY] = ready;
      rd_mux[`SHA256_STS_VALID] = digest_valid;
    end else if (sel_intr_sts) begin
      rd_mux[0] = intr_sts_q;
    end else if (sel_intr_en) begin
      rd_mux[0] = intr_en_q;
    end else if (sel_digest && digest_valid) begin
      // digest hidden until valid
      rd_mux = digest[dig_off[DIG_IDX_W-1:0]];
    end
  end

  // answer, read data and command pulses
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      wb_ack   <= 1'b0;
      wb_err   <= 1'b0;
      wb_dat_r <= '0;
      init_cmd <= 1'b0;
      next_cmd <= 1'b0;
      zeroize  <= 1'b0;
    end else begin
      wb_ack   <= req & mapped;
      wb_err   <= req & ~mapped;
      wb_dat_r <= rd_req ? rd_mux : '0;
      init_cmd <= wr_req & sel_ctrl & wb_dat_w[`SHA256_CTRL_INIT];
      next_cmd <= wr_req & sel_ctrl & wb_dat_w[`SHA256_CTRL_NEXT];
      zeroize  <= wr_req & sel_ctrl & wb_dat_w[`SHA256_CTRL_ZEROIZE];
    end
  end

  // ---------------------------------------------------------------------
  // block registers
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      block <= '0;
    end else if (zeroize) begin
      block <= '0;
    end else if (wr_req && sel_block) begin
      block[blk_off[BLK_IDX_W-1:0]] <= wb_dat_w;
    end
  end

  // ---------------------------------------------------------------------
  // hash-done interrupt
  // ---------------------------------------------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      intr_sts_q <= 1'b0;
      intr_en_q  <= 1'b0;
      valid_q    <= 1'b0;
    end else begin
      valid_q <= digest_valid;
      if (wr_req && sel_intr_en) begin
        intr_en_q <= wb_dat_w[0];
      end
      // set beats a same-cycle w1c
      if (zeroize) begin
        intr_sts_q <= 1'b0;
      end else if (digest_valid && !valid_q) begin
        intr_sts_q <= 1'b1;
      end else if (wr_req && sel_intr_sts && wb_dat_w[0]) begin
        intr_sts_q <= 1'b0;
      end
    end
  end

  // level interrupt
  assign notif_intr = intr_sts_q & intr_en_q;

endmodule

//--- hw/sha256_top.sv
`timescale 1ns/1ps
`include "sha256_macros.svh"

module sha256_top (
  input  logic                     clk,
  input  logic                     reset_n,
  input  logic                     wb_cyc,
  input  logic                     wb_stb,
  input  logic                     wb_we,
  input  logic [`SHA256_ADR_W-1:0] wb_adr,
  input  sha256_pkg::word_t        wb_dat_w,
  output sha256_pkg::word_t        wb_dat_r,
  output logic                     wb_ack,
  output logic                     wb_err,
  output logic                     notif_intr
);
  import sha256_pkg::*;

  // ---------------------------------------------------------------------
  // regs to core
  // ---------------------------------------------------------------------
  logic    init_cmd;
  logic    next_cmd;
  logic    zeroize;
  block_t  block;
  // core back to regs
  logic    ready;
  logic    digest_valid;
  digest_t digest;

  sha256_regs u_sha256_regs (
    .clk          (clk),
    .reset_n      (reset_n),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_we        (wb_we),
    .wb_adr       (wb_adr),
    .wb_dat_w     (wb_dat_w),
    .wb_dat_r     (wb_dat_r),
    .wb_ack       (wb_ack),
    .wb_err       (wb_err),
    .notif_intr   (notif_intr),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .zeroize      (zeroize),
    .block        (block),
    .ready        (ready),
    .digest_valid (digest_valid),
    .digest       (digest)
  );

  sha256_core u_sha256_core (
    .clk          (clk),
    .reset_n      (reset_n),
    .zeroize      (zeroize),
    .init_cmd     (init_cmd),
    .next_cmd     (next_cmd),
    .block        (block),
    .ready        (ready),
    .digest_valid (digest_valid),
    .digest       (digest)
  );

endmodule

//--- project.f
+incdir+hw
hw/sha256_pkg.sv
hw/sha256_msg_schedule.sv
hw/sha256_core.sv
hw/sha256_regs.sv
hw/sha256_top.sv
testbench/sha256_checker.sv
testbench/tb_sha256_top.sv

//--- run_sim.sh
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module tb_sha256_top -f project.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vtb_sha256_top)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "TESTS PASSED"; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1

//--- testbench/sha256_checker.sv
`timescale 1ns/1ps
`include "sha256_macros.svh"

module sha256_checker (
  input logic                     clk,
  input logic                     reset_n,
  input logic                     wb_cyc,
  input logic                     wb_stb,
  input logic                     wb_we,
  input logic [`SHA256_ADR_W-1:0] wb_adr,
  input sha256_pkg::word_t        wb_dat_w,
  input sha256_pkg::word_t        wb_dat_r,
  input logic                     wb_ack,
  input logic                     wb_err,
  input logic                     notif_intr
);
  import sha256_pkg::*;

  // ---------------------------------------------------------------------
  // reference model state
  // ---------------------------------------------------------------------
  // mirrored block registers
  block_t  blk_m;
  // expected chaining value after the last command
  digest_t h_m;
  logic    valid_m;
  // hash started, completion not yet seen on a status read
  logic    pending_m;
  logic    intr_sts_m;
  logic    intr_en_m;
  string   test_name = "reset";
  int      error_count = 0;
  int      read_count = 0;

  task automatic set_test(input string name);
    test_name = name;
  endtask

  task automatic report_mismatch(input string what, input word_t exp, input word_t act);
    $display("FAILED %s: %s expected %08h actual %08h", test_name, what, exp, act);
    error_count++;
  endtask

  task automatic report_fault(input string msg);
    $display("ERROR in %s: %s", test_name, msg);
    error_count++;
  endtask

  // ---------------------------------------------------------------------
  // sha-256 compression, written from the standard
  // ---------------------------------------------------------------------
  function automatic word_t rotr(input word_t x, input int n);
    return (x >> n) | (x << (32 - n));
  endfunction

  function automatic word_t ep0(input word_t x);
    return rotr(x, 2) ^ rotr(x, 13) ^ rotr(x, 22);
  endfunction

  function automatic word_t ep1(input word_t x);
    return rotr(x, 6) ^ rotr(x, 11) ^ rotr(x, 25);
  endfunction

  function automatic word_t sig0(input word_t x);
    return rotr(x, 7) ^ rotr(x, 18) ^ (x >> 3);
  endfunction

  function automatic word_t sig1(input word_t x);
    return rotr(x, 17) ^ rotr(x, 19) ^ (x >> 10);
  endfunction

  function automatic digest_t compress_block(input digest_t h_in, input block_t blk);
    word_t   sched [64];
    word_t   v [8];
    word_t   t1;
    word_t   t2;
    digest_t h_out;
    for (int i = 0; i < 16; i++) begin
      sched[i] = blk[i];
    end
    for (int i = 16; i < 64; i++) begin
      sched[i] = sig1(sched[i-2]) + sched[i-7] + sig0(sched[i-15]) + sched[i-16];
    end
    for (int i = 0; i < 8; i++) begin
      v[i] = h_in[i];
    end
    for (int r = 0; r < 64; r++) begin
      t1 = v[7] + ep1(v[4]) + ((v[4] & v[5]) ^ (~v[4] & v[6])) + sha256_k[r] + sched[r];
      t2 = ep0(v[0]) + ((v[0] & v[1]) ^ (v[0] & v[2]) ^ (v[1] & v[2]));
      // a..h shift down one place
      for (int j = 7; j > 0; j--) begin
        v[j] = v[j-1];
      end
      v[4] = v[4] + t1;
      v[0] = t1 + t2;
    end
    for (int i = 0; i < 8; i++) begin
      h_out[i] = h_in[i] + v[i];
    end
    return h_out;
  endfunction

  // ---------------------------------------------------------------------
  // register map expectations
  // ---------------------------------------------------------------------
  // 0x14..0x17 and nothing else is a hole
  function automatic logic is_mapped(input logic [`SHA256_ADR_W-1:0] adr);
    return (adr <= `SHA256_ADR_INTR_EN) || (adr >= `SHA256_ADR_DIGEST);
  endfunction

  function automatic word_t expected_read(input logic [`SHA256_ADR_W-1:0] adr);
    logic [`SHA256_ADR_W-1:0] off;
    off = adr - `SHA256_ADR_DIGEST;
    if (adr < `SHA256_ADR_CTRL) begin
      return blk_m[adr[3:0]];
    end else if (adr == `SHA256_ADR_STATUS) begin
      return {30'b0, valid_m, 1'b1};
    end else if (adr == `SHA256_ADR_INTR_STS) begin
      return {31'b0, intr_sts_m};
    end else if (adr == `SHA256_ADR_INTR_EN) begin
      return {31'b0, intr_en_m};
    end else if (adr >= `SHA256_ADR_DIGEST) begin
      // digest hidden until valid
      return valid_m ? h_m[off[2:0]] : 32'h0;
    end
    // ctrl reads zero
    return 32'h0;
  endfunction

  task automatic apply_write(input logic [`SHA256_ADR_W-1:0] adr, input word_t dat);
    if (adr < `SHA256_ADR_CTRL) begin
      blk_m[adr[3:0]] = dat;
    end else if (adr == `SHA256_ADR_CTRL) begin
      if (dat[`SHA256_CTRL_ZEROIZE]) begin
        blk_m      = '0;
        h_m        = '0;
        valid_m    = 1'b0;
        pending_m  = 1'b0;
        intr_sts_m = 1'b0;
      end else if ((dat[`SHA256_CTRL_INIT] || dat[`SHA256_CTRL_NEXT]) && !pending_m) begin
        // init starts from the iv, next chains
        h_m       = compress_block(dat[`SHA256_CTRL_INIT] ? sha256_iv : h_m, blk_m);
        pending_m = 1'b1;
        valid_m   = 1'b0;
      end
    end else if (adr == `SHA256_ADR_INTR_STS) begin
      if (dat[0]) begin
        intr_sts_m = 1'b0;
      end
    end else if (adr == `SHA256_ADR_INTR_EN) begin
      intr_en_m = dat[0];
    end
  endtask

  task automatic check_read(input logic [`SHA256_ADR_W-1:0] adr, input word_t act);
    word_t exp;
    logic  pin_exp;
    read_count++;
    if (adr == `SHA256_ADR_STATUS && pending_m) begin
      // busy reads 0, done reads ready and valid together
      if (act == 32'h3) begin
        pending_m  = 1'b0;
        valid_m    = 1'b1;
        intr_sts_m = 1'b1;
      end else if (act != 32'h0) begin
        report_mismatch("status while hashing", 32'h3, act);
      end
    end else begin
      exp = expected_read(adr);
      if (act !== exp) begin
        report_mismatch($sformatf("read of address %02h", adr), exp, act);
      end
    end
    // pin only known once completion was seen
    if (!pending_m) begin
      pin_exp = intr_sts_m & intr_en_m;
      if (notif_intr !== pin_exp) begin
        report_mismatch("notif_intr", {31'b0, pin_exp}, {31'b0, notif_intr});
      end
    end
  endtask

  // ---------------------------------------------------------------------
  // bus monitor, values are stable at the rising edge
  // ---------------------------------------------------------------------
  always @(posedge clk) begin
    if (!reset_n) begin
      blk_m      = '0;
      h_m        = '0;
      valid_m    = 1'b0;
      pending_m  = 1'b0;
      intr_sts_m = 1'b0;
      intr_en_m  = 1'b0;
    end else begin
      if (wb_ack && wb_err) begin
        report_fault("slave answered with ack and err in the same cycle");
      end
      if ((wb_ack || wb_err) && !(wb_cyc && wb_stb)) begin
        report_fault("slave answered without a pending request");
      end
      if (wb_ack && !is_mapped(wb_adr)) begin
        report_fault($sformatf("unmapped address %02h was acked instead of errored", wb_adr));
      end
      if (wb_err && is_mapped(wb_adr)) begin
        report_fault($sformatf("mapped address %02h answered with a bus error", wb_adr));
      end
      if (wb_ack && wb_we) begin
        apply_write(wb_adr, wb_dat_w);
      end
      if (wb_ack && !wb_we) begin
        check_read(wb_adr, wb_dat_r);
      end
    end
  end

endmodule

//--- testbench/tb_sha256_top.sv
`timescale 1ns/1ps
`include "sha256_macros.svh"

module tb_sha256_top;
  import sha256_pkg::*;

  localparam int NUM_CHAIN   = 3;
  // cycles to wait for ack or err
  localparam int BUS_TIMEOUT = 20;
  // status reads before giving up on a hash
  localparam int POLL_LIMIT  = 200;

  logic                     clk;
  logic                     reset_n;
  logic                     wb_cyc;
  logic                     wb_stb;
  logic                     wb_we;
  logic [`SHA256_ADR_W-1:0] wb_adr;
  word_t                    wb_dat_w;
  word_t                    wb_dat_r;
  logic                     wb_ack;
  logic                     wb_err;
  logic                     notif_intr;
  integer                   seed;
  int                       timeouts;

  sha256_top u_sha256_top (
    .clk        (clk),
    .reset_n    (reset_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err),
    .notif_intr (notif_intr)
  );

  sha256_checker u_sha256_checker (
    .clk        (clk),
    .reset_n    (reset_n),
    .wb_cyc     (wb_cyc),
    .wb_stb     (wb_stb),
    .wb_we      (wb_we),
    .wb_adr     (wb_adr),
    .wb_dat_w   (wb_dat_w),
    .wb_dat_r   (wb_dat_r),
    .wb_ack     (wb_ack),
    .wb_err     (wb_err),
    .notif_intr (notif_intr)
  );

  // 10 ns period
  always #5 clk = ~clk;

  // ---------------------------------------------------------------------
  // wishbone host driving on the falling edge
  // ---------------------------------------------------------------------
  task automatic bus_transfer(input logic we, input logic [`SHA256_ADR_W-1:0] adr,
                              input word_t dat, output word_t rdata);
    int waited;
    waited = 0;
    @(negedge clk);
    wb_cyc   = 1'b1;
    wb_stb   = 1'b1;
    wb_we    = we;
    wb_adr   = adr;
    wb_dat_w = dat;
    // hold until ack or err
    while (!wb_ack && !wb_err && waited < BUS_TIMEOUT) begin
      @(negedge clk);
      waited++;
    end
    rdata = wb_dat_r;
    if (!wb_ack && !wb_err) begin
      $display("bus timeout: no ack or err for address %02h", adr);
      timeouts++;
    end else begin
      // request stays up through the rising edge that closes the answer
      @(negedge clk);
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we  = 1'b0;
  endtask

  task automatic write_word(input logic [`SHA256_ADR_W-1:0] adr, input word_t dat);
    word_t unused;
    bus_transfer(1'b1, adr, dat, unused);
  endtask

  task automatic read_word(input logic [`SHA256_ADR_W-1:0] adr, output word_t rdata);
    bus_transfer(1'b0, adr, 32'h0, rdata);
  endtask

  task automatic poll_valid();
    word_t sts;
    int    polls;
    polls = 0;
    sts   = '0;
    while (!sts[`SHA256_STS_VALID] && polls < POLL_LIMIT) begin
      read_word(`SHA256_ADR_STATUS, sts);
      polls++;
    end
    if (!sts[`SHA256_STS_VALID]) begin
      $display("hash did not finish within %0d status reads", POLL_LIMIT);
      timeouts++;
    end
  endtask

  // ---------------------------------------------------------------------
  // stimulus helpers
  // ---------------------------------------------------------------------
  task automatic write_random_block();
    for (int i = 0; i < `SHA256_BLOCK_WORDS; i++) begin
      write_word(`SHA256_ADR_BLOCK + 5'(i), $random(seed));
    end
  endtask

  task automatic read_range(input logic [`SHA256_ADR_W-1:0] base, input int count);
    word_t rdata;
    for (int i = 0; i < count; i++) begin
      read_word(base + 5'(i), rdata);
    end
  endtask

  // new block, start command, wait, read the digest
  task automatic hash_block(input int cmd_bit);
    write_random_block();
    write_word(`SHA256_ADR_CTRL, 32'h1 << cmd_bit);
    poll_valid();
    read_range(`SHA256_ADR_DIGEST, `SHA256_DIGEST_WORDS);
  endtask

  initial begin
    word_t rdata;
    seed     = 61224;
    timeouts = 0;
    clk      = 1'b0;
    reset_n  = 1'b0;
    wb_cyc   = 1'b0;
    wb_stb   = 1'b0;
    wb_we    = 1'b0;
    wb_adr   = '0;
    wb_dat_w = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    // ready only, nothing valid
    u_sha256_checker.set_test("reset_state");
    read_word(`SHA256_ADR_STATUS, rdata);
    read_word(`SHA256_ADR_INTR_STS, rdata);
    read_range(`SHA256_ADR_DIGEST, `SHA256_DIGEST_WORDS);

    u_sha256_checker.set_test("register_access");
    write_random_block();
    read_range(`SHA256_ADR_BLOCK, `SHA256_BLOCK_WORDS);
    read_word(`SHA256_ADR_CTRL, rdata);
    // hole between intr_en and digest
    read_range(5'h14, 4);
    write_word(5'h15, $random(seed));

    u_sha256_checker.set_test("single_block");
    hash_block(`SHA256_CTRL_INIT);

    u_sha256_checker.set_test("chained");
    for (int n = 0; n < NUM_CHAIN; n++) begin
      hash_block(`SHA256_CTRL_NEXT);
    end
    hash_block(`SHA256_CTRL_INIT);

    // wipe, then hash again from scratch
    u_sha256_checker.set_test("zeroize");
    write_word(`SHA256_ADR_CTRL, 32'h1 << `SHA256_CTRL_ZEROIZE);
    read_range(`SHA256_ADR_DIGEST, `SHA256_DIGEST_WORDS);
    read_range(`SHA256_ADR_BLOCK, `SHA256_BLOCK_WORDS);
    read_word(`SHA256_ADR_STATUS, rdata);
    read_word(`SHA256_ADR_INTR_STS, rdata);
    // chaining state is wiped, so next starts from zero
    hash_block(`SHA256_CTRL_NEXT);
    hash_block(`SHA256_CTRL_INIT);

    u_sha256_checker.set_test("interrupt_enabled");
    write_word(`SHA256_ADR_INTR_STS, 32'h1);
    write_word(`SHA256_ADR_INTR_EN, 32'h1);
    hash_block(`SHA256_CTRL_INIT);
    read_word(`SHA256_ADR_INTR_STS, rdata);
    write_word(`SHA256_ADR_INTR_STS, 32'h1);
    read_word(`SHA256_ADR_INTR_STS, rdata);

    u_sha256_checker.set_test("interrupt_disabled");
    write_word(`SHA256_ADR_INTR_EN, 32'h0);
    hash_block(`SHA256_CTRL_NEXT);
    read_word(`SHA256_ADR_INTR_STS, rdata);

    $display("summary: %0d reads checked, %0d check errors, %0d timeouts",
             u_sha256_checker.read_count, u_sha256_checker.error_count, timeouts);
    if (u_sha256_checker.error_count == 0 && timeouts == 0 &&
        u_sha256_checker.read_count > 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
